/* src.f */
common/isa_pkg.sv
common/ctrl_pkg.sv
common/ctrl_word_if.sv
verilog/alu_op_decode.sv
verilog/branch_decode.sv
verilog/mem_ref_decode.sv
verilog/step_select.sv
verilog/controller.sv
dv/controller_chk.sv
dv/tb_controller.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_controller
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_controller.sv */
`timescale 1ns/1ps

module tb_controller
        import isa_pkg::*;
        import ctrl_pkg::*;
();

        localparam int MAX_CYCLES = 2500;       // ~1500 stimulus cycles plus margin

        typedef struct packed {
                logic [3:0] dest_reg;
                logic [3:0] sour_reg;
                logic [7:0] offset;
                logic [1:0] sst;
                logic [1:0] sci;
                logic [1:0] rec;
                logic [3:0] alu_func;
                logic [3:0] alu_in_sel;
                logic       en_reg;
                logic       en_pc;
                logic       wr;
        } cw_t;

        // function code per register ALU opcode 0x00..0x15
        localparam logic [3:0] ALU_FN [22] = '{4'd0, 4'd1, 4'd2, 4'd1, 4'd4, 4'd2, 4'd3, 4'd0,
                4'd1, 4'd0, 4'd5, 4'd6, 4'd0, 4'd1, 4'd7, 4'd8, 4'd9, 4'd10, 4'd11, 4'd12,
                4'd13, 4'd14};
        localparam logic [7:0] BR_OPS [9] = '{OP_JMP, OP_JS, OP_JNS, OP_JC, OP_JNC, OP_JZ,
                OP_JNZ, OP_CLC, OP_STC};
        localparam step_t FETCH_STEPS [3] = '{STEP_FETCH0, STEP_FETCH1, STEP_FETCH2};

        logic        clk;
        logic        reset;
        step_t       timer;
        instr_u      instruction;
        logic        c;
        logic        z;
        logic        s;
        logic [3:0]  dest_reg;
        logic [3:0]  sour_reg;
        logic [7:0]  offset;
        logic [1:0]  sst;
        logic [1:0]  sci;
        logic [1:0]  rec;
        logic [3:0]  alu_func;
        logic [3:0]  alu_in_sel;
        logic        en_reg;
        logic        en_pc;
        logic        wr;
        cw_t         dut_word;

        int seed = 46236;
        int checks = 0;
        int errors = 0;
        int cycles = 0;

        controller u_dut (.*);

        assign dut_word = {dest_reg, sour_reg, offset, sst, sci, rec, alu_func, alu_in_sel,
                en_reg, en_pc, wr};

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("timeout: run stopped after %0d cycles", cycles);
                        $display("FAIL: see errors above");
                        $finish;
                end
        end

        function automatic int rand_below(input int n);
                int r;
                r = $random(seed) & 32'h7fff_ffff;
                return r % n;
        endfunction

        function automatic logic is_branch(input logic [7:0] op);
                return op inside {[OP_JMP:OP_JS], [OP_JNS:OP_JNZ], OP_CLC, OP_STC};
        endfunction

        function automatic cw_t idle_word();
                cw_t e;
                e = '0;
                e.sst = ST_KEEP;
                e.wr = 1'b1;
                return e;
        endfunction

        function automatic cw_t alu_word(input logic [15:0] ins);
                cw_t e;
                logic [7:0] op;
                op = ins[15:8];
                e = idle_word();
                e.dest_reg = ins[7:4];
                e.sour_reg = ins[3:0];
                e.sst = ST_ALU;
                e.alu_func = ALU_FN[op[4:0]];
                e.en_reg = !(op inside {OP_CMP, OP_TEST});      // flags only
                if (op == OP_MVRR) begin
                        e.alu_in_sel = IN_SR;
                        e.sst = ST_KEEP;
                end
                if (op inside {OP_DEC, OP_INC}) begin
                        e.sci = CI_ONE;
                        e.alu_in_sel = IN_DR;
                end
                if (op inside {[OP_ADC:OP_MUL]})
                        e.sci = CI_FLAG;
                if (op inside {OP_RBIT, OP_REV})
                        e.alu_in_sel = IN_DR;
                return e;
        endfunction

        function automatic cw_t branch_word(input logic [15:0] ins, input logic fc,
                        input logic fz, input logic fs);
                cw_t e;
                e = idle_word();
                e.offset = ins[7:0];
                case (ins[15:8])
                        OP_CLC: e.sst = ST_CLC;
                        OP_STC: e.sst = ST_STC;
                        OP_JMP: e.en_pc = 1'b1;
                        OP_JC:  e.en_pc = fc;
                        OP_JNC: e.en_pc = !fc;
                        OP_JZ:  e.en_pc = fz;
                        OP_JNZ: e.en_pc = !fz;
                        OP_JS:  e.en_pc = fs;
                        OP_JNS: e.en_pc = !fs;
                        default: ;
                endcase
                if (!(ins[15:8] inside {OP_CLC, OP_STC}))
                        e.alu_in_sel = IN_PC_OFS;
                return e;
        endfunction

        function automatic cw_t mem_word(input logic [15:0] ins, input logic second);
                cw_t e;
                logic [7:0] op;
                op = ins[15:8];
                e = idle_word();
                e.dest_reg = ins[7:4];
                e.sour_reg = ins[3:0];
                if (!second && op inside {OP_JMPA, OP_MVRD}) begin
                        e.sci = CI_ONE;
                        e.en_pc = 1'b1;
                        e.alu_in_sel = IN_PC;
                        e.rec = RC_AR_PC;
                end else if (!second) begin
                        e.alu_in_sel = (op == OP_LDRR) ? IN_SR : IN_DR;
                        e.rec = RC_AR_ALU;
                end else begin
                        e.alu_in_sel = (op == OP_STRR) ? IN_SR : IN_MEM;
                        e.en_pc = (op == OP_JMPA);
                        e.en_reg = op inside {OP_MVRD, OP_LDRR};
                        e.wr = (op != OP_STRR);                 // store writes memory
                end
                return e;
        endfunction

        function automatic cw_t model_word(input step_t step, input logic [15:0] ins,
                        input logic fc, input logic fz, input logic fs);
                cw_t e;
                logic [7:0] op;
                op = ins[15:8];
                e = idle_word();
                case (step)
                        STEP_FETCH1: begin
                                e.sci = CI_ONE;
                                e.en_pc = 1'b1;
                                e.alu_in_sel = IN_PC;
                                e.rec = RC_AR_PC;
                        end
                        STEP_FETCH2: e.rec = RC_IR;
                        STEP_EXEC: begin
                                if (op <= OP_REV)
                                        e = alu_word(ins);
                                else if (is_branch(op))
                                        e = branch_word(ins, fc, fz, fs);
                        end
                        STEP_MEM1, STEP_MEM2: begin
                                if (op inside {[OP_JMPA:OP_STRR]})
                                        e = mem_word(ins, step == STEP_MEM2);
                        end
                        default: ;      // fetch0 and undefined steps stay idle
                endcase
                return e;
        endfunction

        task automatic apply_and_check(input string name, input step_t step,
                        input logic [15:0] ins, input logic [2:0] flags);
                cw_t want;
                @(posedge clk);
                #1;
                timer = step;
                instruction = ins;
                {c, z, s} = flags;
                #2;
                want = model_word(step, ins, flags[2], flags[1], flags[0]);
                checks++;
                assert (dut_word === want) else begin
                        errors++;
                        $display("** Error @ %0t: %s step %b instr %h czs %b expected %h got %h",
                                $time, name, step, ins, flags, want, dut_word);
                end
        endtask

        // kind 0 fetch, 1 alu, 2 branch, 3 mem pair, 4 idle cases
        task automatic run_batch(input string name, input int kind, input int n);
                int c0;
                int e0;
                logic [31:0] r;
                logic [7:0] op;
                step_t step;
                c0 = checks;
                e0 = errors;
                for (int i = 0; i < n; i++) begin
                        r = $random(seed);
                        op = r[15:8];
                        step = STEP_EXEC;
                        case (kind)
                                0: step = FETCH_STEPS[rand_below(3)];
                                1: op = 8'(rand_below(22));
                                2: op = BR_OPS[rand_below(9)];
                                3: begin
                                        op = 8'h80 + 8'(rand_below(4));
                                        step = STEP_MEM1;
                                end
                                4: begin
                                        case (rand_below(3))
                                                0: step = r[24] ? 3'b110 : 3'b010;
                                                1: while (op <= OP_REV || is_branch(op))
                                                        op = 8'($random(seed));
                                                default: begin
                                                        step = r[24] ? STEP_MEM2 : STEP_MEM1;
                                                        while (op inside {[OP_JMPA:OP_STRR]})
                                                                op = 8'($random(seed));
                                                end
                                        endcase
                                end
                                default: ;
                        endcase
                        apply_and_check(name, step, {op, r[7:0]}, r[30:28]);
                        if (kind == 3)
                                apply_and_check(name, STEP_MEM2, {op, r[7:0]}, r[30:28]);
                end
                $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
        endtask

        initial begin
                timer = STEP_FETCH0;
                instruction = '0;
                c = 1'b0;
                z = 1'b0;
                s = 1'b0;
                reset = 1'b1;
                repeat (4) @(posedge clk);
                #1 reset = 1'b0;
                run_batch("fetch", 0, 200);
                run_batch("alu_ops", 1, 400);
                run_batch("branch", 2, 400);
                run_batch("mem_ref", 3, 100);
                run_batch("idle", 4, 300);
                errors += u_dut.u_chk.fail_count;       // bound property failures
                $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("PASS: all tests");
                else
                        $display("FAIL: see errors above");
                $finish;
        end

endmodule

/* dv/controller_chk.sv */
`timescale 1ns/1ps

module controller_chk
        import ctrl_pkg::*;
(
        input logic [2:0] timer,
        input logic [1:0] sst,
        input logic       en_reg,
        input logic       en_pc,
        input logic       wr
);

        logic samp;
        int   fail_count = 0;

        initial begin
                samp = 1'b0;
                #2;
                forever #2 samp = ~samp;        // rises between stimulus changes
        end

        a_one_enable: assert property (@(posedge samp) !(en_reg && en_pc))
                else begin
                        fail_count++;
                        $error("en_reg and en_pc high together");
                end

        a_wr_mem2: assert property (@(posedge samp) !wr |-> timer == 3'b111)
                else begin
                        fail_count++;
                        $error("wr low outside step 111");
                end

        a_keep_on_pc: assert property (@(posedge samp) en_pc |-> sst == ST_KEEP)
                else begin
                        fail_count++;
                        $error("flags updated while pc loads");
                end

endmodule

bind controller controller_chk u_chk (
        .timer(timer),
        .sst(sst),
        .en_reg(en_reg),
        .en_pc(en_pc),
        .wr(wr)
);

/* verilog/controller.sv */
`timescale 1ns/1ps

module controller
        import isa_pkg::*;
        import ctrl_pkg::*;
(
        input step_t              timer,
        input instr_u             instruction,
        input logic               c,
        input logic               z,
        input logic               s,
        output logic [REG_W-1:0]  dest_reg,
        output logic [REG_W-1:0]  sour_reg,
        output logic [OFS_W-1:0]  offset,
        output logic [CODE_W-1:0] sst,
        output logic [CODE_W-1:0] sci,
        output logic [CODE_W-1:0] rec,
        output logic [FUNC_W-1:0] alu_func,
        output logic [SEL_W-1:0]  alu_in_sel,
        output logic              en_reg,
        output logic              en_pc,
        output logic              wr
);

        ctrl_word_if w_alu ();
        ctrl_word_if w_br ();
        ctrl_word_if w_mem1 ();
        ctrl_word_if w_mem2 ();

        alu_op_decode u_alu_dec (
                .instr(instruction),
                .w(w_alu)
        );

        branch_decode u_br_dec (
                .instr(instruction),
                .c(c),
                .z(z),
                .s(s),
                .w(w_br)
        );

        mem_ref_decode u_mem_dec (
                .instr(instruction),
                .first(w_mem1),
                .second(w_mem2)
        );

        step_select u_step_sel (
                .timer(timer),
                .alu(w_alu),
                .br(w_br),
                .mem1(w_mem1),
                .mem2(w_mem2),
                .dest_reg(dest_reg),
                .sour_reg(sour_reg),
                .offset(offset),
                .sst(sst),
                .sci(sci),
                .rec(rec),
                .alu_func(alu_func),
                .alu_in_sel(alu_in_sel),
                .en_reg(en_reg),
                .en_pc(en_pc),
                .wr(wr)
        );

endmodule

/* verilog/step_select.sv */
`timescale 1ns/1ps

module step_select
        import isa_pkg::*;
        import ctrl_pkg::*;
(
        input step_t              timer,
        ctrl_word_if.sink         alu,
        ctrl_word_if.sink         br,
        ctrl_word_if.sink         mem1,
        ctrl_word_if.sink         mem2,
        output logic [REG_W-1:0]  dest_reg,
        output logic [REG_W-1:0]  sour_reg,
        output logic [OFS_W-1:0]  offset,
        output logic [CODE_W-1:0] sst,
        output logic [CODE_W-1:0] sci,
        output logic [CODE_W-1:0] rec,
        output logic [FUNC_W-1:0] alu_func,
        output logic [SEL_W-1:0]  alu_in_sel,
        output logic              en_reg,
        output logic              en_pc,
        output logic              wr
);

        logic [CW_W-1:0] alu_w;
        logic [CW_W-1:0] br_w;
        logic [CW_W-1:0] mem1_w;
        logic [CW_W-1:0] mem2_w;
        logic [CW_W-1:0] word;

        assign alu_w = {alu.dest_reg, alu.sour_reg, alu.offset, alu.sst, alu.sci, alu.rec,
                alu.alu_func, alu.alu_in_sel, alu.en_reg, alu.en_pc, alu.wr};
        assign br_w = {br.dest_reg, br.sour_reg, br.offset, br.sst, br.sci, br.rec,
                br.alu_func, br.alu_in_sel, br.en_reg, br.en_pc, br.wr};
        assign mem1_w = {mem1.dest_reg, mem1.sour_reg, mem1.offset, mem1.sst, mem1.sci,
                mem1.rec, mem1.alu_func, mem1.alu_in_sel, mem1.en_reg, mem1.en_pc, mem1.wr};
        assign mem2_w = {mem2.dest_reg, mem2.sour_reg, mem2.offset, mem2.sst, mem2.sci,
                mem2.rec, mem2.alu_func, mem2.alu_in_sel, mem2.en_reg, mem2.en_pc, mem2.wr};

        always_comb begin
                word = IDLE_WORD;       // undefined steps and misses
                case (timer)
                        STEP_FETCH0: word = IDLE_WORD;
                        STEP_FETCH1: word = FETCH1_WORD;
                        STEP_FETCH2: word = FETCH2_WORD;
                        STEP_EXEC: begin
                                if (alu.hit)
                                        word = alu_w;
                                else if (br.hit)
                                        word = br_w;
                        end
                        STEP_MEM1: if (mem1.hit) word = mem1_w;
                        STEP_MEM2: if (mem2.hit) word = mem2_w;
                        default: word = IDLE_WORD;
                endcase
        end

        assign {dest_reg, sour_reg, offset, sst, sci, rec, alu_func, alu_in_sel,
                en_reg, en_pc, wr} = word;

endmodule

/* verilog/mem_ref_decode.sv */
`timescale 1ns/1ps

module mem_ref_decode
        import isa_pkg::*;
        import ctrl_pkg::*;
(
        input instr_u    instr,
        ctrl_word_if.src first,
        ctrl_word_if.src second
);

        // address step
        always_comb begin
                first.hit = 1'b1;
                first.dest_reg = instr.rr.dest;
                first.sour_reg = instr.rr.sour;
                first.offset = '0;
                first.sci = CI_ZERO;
                first.sst = ST_KEEP;
                first.rec = RC_NONE;
                first.alu_func = FN_ADD;
                first.alu_in_sel = IN_RR;
                first.en_reg = 1'b0;
                first.en_pc = 1'b0;
                first.wr = 1'b1;
                case (instr.rr.opcode)
                        OP_JMPA, OP_MVRD: begin         // operand word follows the opcode
                                first.sci = CI_ONE;
                                first.en_pc = 1'b1;
                                first.alu_in_sel = IN_PC;
                                first.rec = RC_AR_PC;
                        end
                        OP_LDRR: begin
                                first.alu_in_sel = IN_SR;
                                first.rec = RC_AR_ALU;
                        end
                        OP_STRR: begin
                                first.alu_in_sel = IN_DR;
                                first.rec = RC_AR_ALU;
                        end
                        default: first.hit = 1'b0;
                endcase
        end

        // data step
        always_comb begin
                second.hit = 1'b1;
                second.dest_reg = instr.rr.dest;
                second.sour_reg = instr.rr.sour;
                second.offset = '0;
                second.sci = CI_ZERO;
                second.sst = ST_KEEP;
                second.rec = RC_NONE;
                second.alu_func = FN_ADD;
                second.alu_in_sel = IN_MEM;
                second.en_reg = 1'b0;
                second.en_pc = 1'b0;
                second.wr = 1'b1;
                case (instr.rr.opcode)
                        OP_JMPA:          second.en_pc = 1'b1;
                        OP_MVRD, OP_LDRR: second.en_reg = 1'b1;
                        OP_STRR: begin
                                second.alu_in_sel = IN_SR;      // sr onto the bus
                                second.wr = 1'b0;
                        end
                        default: second.hit = 1'b0;
                endcase
        end

endmodule

/* verilog/branch_decode.sv */
`timescale 1ns/1ps

module branch_decode
        import isa_pkg::*;
        import ctrl_pkg::*;
(
        input instr_u    instr,
        input logic      c,
        input logic      z,
        input logic      s,
        ctrl_word_if.src w
);

        always_comb begin
                w.hit = 1'b1;
                w.dest_reg = '0;
                w.sour_reg = '0;
                w.offset = instr.ofs.offset;
                w.sci = CI_ZERO;
                w.sst = ST_KEEP;
                w.rec = RC_NONE;
                w.alu_func = FN_ADD;
                w.alu_in_sel = IN_PC_OFS;       // pc + offset
                w.en_reg = 1'b0;
                w.en_pc = 1'b0;
                w.wr = 1'b1;
                case (instr.ofs.opcode)
                        OP_JMP: w.en_pc = 1'b1;
                        OP_JS:  w.en_pc = s;
                        OP_JNS: w.en_pc = ~s;
                        OP_JC:  w.en_pc = c;
                        OP_JNC: w.en_pc = ~c;
                        OP_JZ:  w.en_pc = z;
                        OP_JNZ: w.en_pc = ~z;
                        OP_CLC: begin
                                w.sst = ST_CLC;
                                w.alu_in_sel = IN_RR;
                        end
                        OP_STC: begin
                                w.sst = ST_STC;
                                w.alu_in_sel = IN_RR;
                        end
                        default: w.hit = 1'b0;
                endcase
        end

endmodule

/* verilog/alu_op_decode.sv */
`timescale 1ns/1ps

module alu_op_decode
        import isa_pkg::*;
        import ctrl_pkg::*;
(
        input instr_u    instr,
        ctrl_word_if.src w
);

        always_comb begin
                w.hit = 1'b1;
                w.dest_reg = instr.rr.dest;
                w.sour_reg = instr.rr.sour;
                w.offset = '0;
                w.sci = CI_ZERO;
                w.sst = ST_ALU;
                w.rec = RC_NONE;
                w.alu_func = FN_ADD;
                w.alu_in_sel = IN_RR;
                w.en_reg = 1'b1;
                w.en_pc = 1'b0;
                w.wr = 1'b1;
                case (instr.rr.opcode)
                        OP_ADD:  w.alu_func = FN_ADD;
                        OP_SUB:  w.alu_func = FN_SUB;
                        OP_AND:  w.alu_func = FN_AND;
                        OP_XOR:  w.alu_func = FN_XOR;
                        OP_OR:   w.alu_func = FN_OR;
                        OP_CMP: begin
                                w.alu_func = FN_SUB;
                                w.en_reg = 1'b0;        // flags only
                        end
                        OP_TEST: begin
                                w.alu_func = FN_AND;
                                w.en_reg = 1'b0;
                        end
                        OP_MVRR: begin
                                w.alu_in_sel = IN_SR;
                                w.sst = ST_KEEP;
                        end
                        OP_DEC, OP_INC: begin
                                w.sci = CI_ONE;
                                w.alu_in_sel = IN_DR;
                                w.alu_func = (instr.rr.opcode == OP_DEC) ? FN_SUB : FN_ADD;
                        end
                        OP_SHL:  w.alu_func = FN_SHL;
                        OP_SHR:  w.alu_func = FN_SHR;
                        OP_ADC:  w.alu_func = FN_ADD;
                        OP_SBB:  w.alu_func = FN_SUB;
                        OP_NOT:  w.alu_func = FN_NOT;
                        OP_DIV:  w.alu_func = FN_DIV;
                        OP_MUL:  w.alu_func = FN_MUL;
                        OP_ROL:  w.alu_func = FN_ROL;
                        OP_ROR:  w.alu_func = FN_ROR;
                        OP_SAR:  w.alu_func = FN_SAR;
                        OP_RBIT, OP_REV: begin
                                w.alu_in_sel = IN_DR;   // bit or byte reversal of dr
                                w.alu_func = (instr.rr.opcode == OP_RBIT) ? FN_RBIT : FN_REV;
                        end
                        default: w.hit = 1'b0;
                endcase
                if (instr.rr.opcode inside {[OP_ADC:OP_MUL]})
                        w.sci = CI_FLAG;        // carry in from c
        end

endmodule

/* common/ctrl_word_if.sv */
`timescale 1ns/1ps

interface ctrl_word_if
        import isa_pkg::*;
        import ctrl_pkg::*;
();
        logic [REG_W-1:0] dest_reg;
        logic [REG_W-1:0] sour_reg;
        logic [OFS_W-1:0] offset;
        sci_t             sci;
        sst_t             sst;
        rec_t             rec;
        alu_func_t        alu_func;
        in_sel_t          alu_in_sel;
        logic             en_reg;
        logic             en_pc;
        logic             wr;       // low writes memory
        logic             hit;      // decoder knows the opcode

        modport src (output dest_reg, sour_reg, offset, sci, sst, rec, alu_func,
                alu_in_sel, en_reg, en_pc, wr, hit);

        modport sink (input dest_reg, sour_reg, offset, sci, sst, rec, alu_func,
                alu_in_sel, en_reg, en_pc, wr, hit);

endinterface

/* common/ctrl_pkg.sv */
package ctrl_pkg;

        localparam int CODE_W = 2;
        localparam int FUNC_W = 4;
        localparam int SEL_W  = 4;
        localparam int ARG_W  = 2*isa_pkg::REG_W + isa_pkg::OFS_W;     // dest, sour, offset
        localparam int CW_W   = ARG_W + 3*CODE_W + FUNC_W + SEL_W + 3;

        typedef enum logic [FUNC_W-1:0] {
                FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR,
                FN_SHL, FN_SHR, FN_NOT, FN_DIV, FN_MUL,
                FN_ROL, FN_ROR, FN_SAR, FN_RBIT, FN_REV
        } alu_func_t;

        typedef enum logic [SEL_W-1:0] {
                IN_RR, IN_SR, IN_DR, IN_PC_OFS, IN_PC, IN_MEM
        } in_sel_t;

        typedef enum logic [CODE_W-1:0] {CI_ZERO, CI_ONE, CI_FLAG} sci_t;
        typedef enum logic [CODE_W-1:0] {ST_ALU, ST_CLC, ST_STC, ST_KEEP} sst_t;
        typedef enum logic [CODE_W-1:0] {RC_NONE, RC_AR_PC, RC_IR, RC_AR_ALU} rec_t;

        // word order: dest sour offset sst sci rec func in_sel en_reg en_pc wr
        localparam logic [CW_W-1:0] IDLE_WORD = {
                {ARG_W{1'b0}}, ST_KEEP, CI_ZERO, RC_NONE, FN_ADD, IN_RR, 1'b0, 1'b0, 1'b1
        };

        localparam logic [CW_W-1:0] FETCH1_WORD = {     // pc + 1 into pc and ar
                {ARG_W{1'b0}}, ST_KEEP, CI_ONE, RC_AR_PC, FN_ADD, IN_PC, 1'b0, 1'b1, 1'b1
        };

        localparam logic [CW_W-1:0] FETCH2_WORD = {     // load ir
                {ARG_W{1'b0}}, ST_KEEP, CI_ZERO, RC_IR, FN_ADD, IN_RR, 1'b0, 1'b0, 1'b1
        };

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

        localparam int OPC_W = 8;
        localparam int REG_W = 4;
        localparam int OFS_W = 8;

        // one instruction word, two field layouts
        typedef union packed {
                struct packed {
                        logic [OPC_W-1:0] opcode;
                        logic [REG_W-1:0] dest;
                        logic [REG_W-1:0] sour;
                } rr;
                struct packed {
                        logic [OPC_W-1:0] opcode;
                        logic [OFS_W-1:0] offset;
                } ofs;
        } instr_u;

        typedef logic [2:0] step_t;

        localparam step_t STEP_FETCH0 = 3'b100;
        localparam step_t STEP_FETCH1 = 3'b000;
        localparam step_t STEP_FETCH2 = 3'b001;
        localparam step_t STEP_EXEC   = 3'b011;
        localparam step_t STEP_MEM1   = 3'b101;
        localparam step_t STEP_MEM2   = 3'b111;

        localparam logic [OPC_W-1:0] OP_ADD  = 8'h00;
        localparam logic [OPC_W-1:0] OP_SUB  = 8'h01;
        localparam logic [OPC_W-1:0] OP_AND  = 8'h02;
        localparam logic [OPC_W-1:0] OP_CMP  = 8'h03;
        localparam logic [OPC_W-1:0] OP_XOR  = 8'h04;
        localparam logic [OPC_W-1:0] OP_TEST = 8'h05;
        localparam logic [OPC_W-1:0] OP_OR   = 8'h06;
        localparam logic [OPC_W-1:0] OP_MVRR = 8'h07;
        localparam logic [OPC_W-1:0] OP_DEC  = 8'h08;
        localparam logic [OPC_W-1:0] OP_INC  = 8'h09;
        localparam logic [OPC_W-1:0] OP_SHL  = 8'h0A;
        localparam logic [OPC_W-1:0] OP_SHR  = 8'h0B;
        localparam logic [OPC_W-1:0] OP_ADC  = 8'h0C;
        localparam logic [OPC_W-1:0] OP_SBB  = 8'h0D;
        localparam logic [OPC_W-1:0] OP_NOT  = 8'h0E;
        localparam logic [OPC_W-1:0] OP_DIV  = 8'h0F;
        localparam logic [OPC_W-1:0] OP_MUL  = 8'h10;
        localparam logic [OPC_W-1:0] OP_ROL  = 8'h11;
        localparam logic [OPC_W-1:0] OP_ROR  = 8'h12;
        localparam logic [OPC_W-1:0] OP_SAR  = 8'h13;
        localparam logic [OPC_W-1:0] OP_RBIT = 8'h14;
        localparam logic [OPC_W-1:0] OP_REV  = 8'h15;

        localparam logic [OPC_W-1:0] OP_JMP  = 8'h40;
        localparam logic [OPC_W-1:0] OP_JS   = 8'h41;
        localparam logic [OPC_W-1:0] OP_JNS  = 8'h43;
        localparam logic [OPC_W-1:0] OP_JC   = 8'h44;
        localparam logic [OPC_W-1:0] OP_JNC  = 8'h45;
        localparam logic [OPC_W-1:0] OP_JZ   = 8'h46;
        localparam logic [OPC_W-1:0] OP_JNZ  = 8'h47;
        localparam logic [OPC_W-1:0] OP_CLC  = 8'h78;
        localparam logic [OPC_W-1:0] OP_STC  = 8'h7A;

        localparam logic [OPC_W-1:0] OP_JMPA = 8'h80;
        localparam logic [OPC_W-1:0] OP_MVRD = 8'h81;
        localparam logic [OPC_W-1:0] OP_LDRR = 8'h82;
        localparam logic [OPC_W-1:0] OP_STRR = 8'h83;

endpackage
